//--- source/rsPkg.sv
package rsPkg;

    // ****************************************
    // datapath and tag widths
    // ****************************************
    localparam int DataWidth = 32;  // operand and result width.
    localparam int TagWidth  = 4;   // tag 0 means value present.

    // ****************************************
    // station sizing
    // ****************************************
    localparam int NumEntries = 8;
    localparam int SlotWidth  = $clog2(NumEntries);
    localparam int CreditInit = NumEntries;  // upstream credits after reset or flush.

    // ****************************************
    // opcodes
    // ****************************************
    typedef enum logic [2:0] {
        opAdd = 3'd0,
        opSub = 3'd1,
        opAnd = 3'd2,
        opOr  = 3'd3,
        opXor = 3'd4,
        opShl = 3'd5,  // shift amount from low 5 bits of b.
        opShr = 3'd6,  // logical.
        opSlt = 3'd7   // signed compare, gives 1 or 0.
    } rsOp;

endpackage

//--- source/rsEntry.sv
`timescale 1ns/1ps

module rsEntry import rsPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 writeEnable,
    input  rsOp                  inOp,
    input  logic [TagWidth-1:0]  inDestTag,
    input  logic [TagWidth-1:0]  inTagA,
    input  logic [TagWidth-1:0]  inTagB,
    input  logic [DataWidth-1:0] inValA,
    input  logic [DataWidth-1:0] inValB,
    input  logic                 resultValid,
    input  logic [TagWidth-1:0]  resultTag,
    input  logic [DataWidth-1:0] resultData,
    input  logic                 issueClear,
    output logic                 busy,
    output logic                 ready,
    output rsOp                  op,
    output logic [TagWidth-1:0]  destTag,
    output logic [DataWidth-1:0] valA,
    output logic [DataWidth-1:0] valB
);

    logic [TagWidth-1:0]  tagA;
    logic [TagWidth-1:0]  tagB;
    logic [DataWidth-1:0] dataA;
    logic [DataWidth-1:0] dataB;
    logic                 hitA;
    logic                 hitB;
    logic                 newHitA;
    logic                 newHitB;

    // snoop for resident operands.
    assign hitA = resultValid && (tagA != '0) && (tagA == resultTag);
    assign hitB = resultValid && (tagB != '0) && (tagB == resultTag);

    // snoop for operands arriving this cycle.
    assign newHitA = resultValid && (inTagA != '0) && (inTagA == resultTag);
    assign newHitB = resultValid && (inTagB != '0) && (inTagB == resultTag);

    // a broadcast hit counts as present, the data is forwarded.
    assign ready = busy && ((tagA == '0) || hitA) && ((tagB == '0) || hitB);
    assign valA  = hitA ? resultData : dataA;
    assign valB  = hitB ? resultData : dataB;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            busy <= 1'b0;
            tagA <= '0;
            tagB <= '0;
        end else if (issueClear) begin
            busy <= 1'b0;  // taken by issue.
        end else if (writeEnable) begin
            busy    <= 1'b1;
            op      <= inOp;
            destTag <= inDestTag;
            tagA    <= newHitA ? '0 : inTagA;
            tagB    <= newHitB ? '0 : inTagB;
            dataA   <= newHitA ? resultData : inValA;
            dataB   <= newHitB ? resultData : inValB;
        end else begin
            if (hitA) begin
                tagA  <= '0;
                dataA <= resultData;
            end
            if (hitB) begin
                tagB  <= '0;
                dataB <= resultData;
            end
        end
    end

endmodule

//--- source/rsDispatch.sv
`timescale 1ns/1ps

module rsDispatch import rsPkg::*; (
    input  logic                  inValid,
    input  logic [NumEntries-1:0] busyVec,
    output logic [NumEntries-1:0] writeEnable
);

    logic [NumEntries-1:0] freeVec;
    logic [NumEntries-1:0] lowestFree;

    assign freeVec = ~busyVec;

    // ****************************************
    // lowest free slot, priority to slot 0
    // ****************************************
    always_comb begin
        logic found;
        found      = 1'b0;
        lowestFree = '0;
        for (int i = 0; i < NumEntries; i++) begin
            if (!found && freeVec[i]) begin
                lowestFree[i] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // credits keep a free slot available whenever inValid is high.
    assign writeEnable = inValid ? lowestFree : '0;

endmodule

//--- source/rsIssue.sv
`timescale 1ns/1ps

module rsIssue import rsPkg::*; (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  flush,
    input  logic [NumEntries-1:0]                 readyVec,
    input  rsOp  [NumEntries-1:0]                 opVec,
    input  logic [NumEntries-1:0][TagWidth-1:0]   tagVec,
    input  logic [NumEntries-1:0][DataWidth-1:0]  valAVec,
    input  logic [NumEntries-1:0][DataWidth-1:0]  valBVec,
    output logic [NumEntries-1:0]                 issueClear,
    output logic                                  issueValid,
    output rsOp                                   issueOp,
    output logic [TagWidth-1:0]                   issueTag,
    output logic [DataWidth-1:0]                  issueA,
    output logic [DataWidth-1:0]                  issueB,
    output logic                                  creditReturn
);

    logic [SlotWidth-1:0] selSlot;
    logic                 anyReady;

    // ****************************************
    // lowest ready slot
    // ****************************************
    always_comb begin
        selSlot  = '0;
        anyReady = 1'b0;
        for (int i = NumEntries - 1; i >= 0; i--) begin
            if (readyVec[i]) begin
                selSlot  = SlotWidth'(i);  // lower index wins.
                anyReady = 1'b1;
            end
        end
    end

    always_comb begin
        issueClear = '0;
        if (anyReady) begin
            issueClear[selSlot] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            issueValid <= 1'b0;
        end else begin
            issueValid <= anyReady;
        end
    end

    always_ff @(posedge clk) begin
        issueOp  <= opVec[selSlot];
        issueTag <= tagVec[selSlot];
        issueA   <= valAVec[selSlot];
        issueB   <= valBVec[selSlot];
    end

    // one credit per slot released.
    assign creditReturn = issueValid;

endmodule

//--- source/rsAlu.sv
`timescale 1ns/1ps

module rsAlu import rsPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 issueValid,
    input  rsOp                  issueOp,
    input  logic [TagWidth-1:0]  issueTag,
    input  logic [DataWidth-1:0] issueA,
    input  logic [DataWidth-1:0] issueB,
    output logic                 resultValid,
    output logic [TagWidth-1:0]  resultTag,
    output logic [DataWidth-1:0] resultData
);

    logic [DataWidth-1:0] aluOut;
    logic [4:0]           shAmt;

    assign shAmt = issueB[4:0];

    always_comb begin
        case (issueOp)
            opAdd:   aluOut = issueA + issueB;
            opSub:   aluOut = issueA - issueB;
            opAnd:   aluOut = issueA & issueB;
            opOr:    aluOut = issueA | issueB;
            opXor:   aluOut = issueA ^ issueB;
            opShl:   aluOut = issueA << shAmt;
            opShr:   aluOut = issueA >> shAmt;
            opSlt:   aluOut = DataWidth'($signed(issueA) < $signed(issueB));
            default: aluOut = '0;
        endcase
    end

    // ****************************************
    // result broadcast register
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            resultValid <= 1'b0;  // drops the in-flight result.
        end else begin
            resultValid <= issueValid;
        end
        resultTag  <= issueTag;
        resultData <= aluOut;
    end

endmodule

//--- source/rsTop.sv
`timescale 1ns/1ps

module rsTop import rsPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 inValid,
    input  rsOp                  inOp,
    input  logic [TagWidth-1:0]  inDestTag,
    input  logic [TagWidth-1:0]  inTagA,
    input  logic [DataWidth-1:0] inValA,
    input  logic [TagWidth-1:0]  inTagB,
    input  logic [DataWidth-1:0] inValB,
    output logic                 creditReturn,
    output logic                 resultValid,
    output logic [TagWidth-1:0]  resultTag,
    output logic [DataWidth-1:0] resultData
);

    logic [NumEntries-1:0]                busyVec;
    logic [NumEntries-1:0]                readyVec;
    logic [NumEntries-1:0]                writeEnable;
    logic [NumEntries-1:0]                issueClear;
    rsOp  [NumEntries-1:0]                opVec;
    logic [NumEntries-1:0][TagWidth-1:0]  tagVec;
    logic [NumEntries-1:0][DataWidth-1:0] valAVec;
    logic [NumEntries-1:0][DataWidth-1:0] valBVec;
    logic                                 issueValid;
    rsOp                                  issueOp;
    logic [TagWidth-1:0]                  issueTag;
    logic [DataWidth-1:0]                 issueA;
    logic [DataWidth-1:0]                 issueB;

    rsDispatch dispatchInst (
        .inValid     (inValid),
        .busyVec     (busyVec),
        .writeEnable (writeEnable)
    );

    // ****************************************
    // station entries
    // ****************************************
    for (genvar i = 0; i < NumEntries; i++) begin : gEntry
        rsEntry entryInst (
            .clk         (clk),
            .reset       (reset),
            .flush       (flush),
            .writeEnable (writeEnable[i]),
            .inOp        (inOp),
            .inDestTag   (inDestTag),
            .inTagA      (inTagA),
            .inTagB      (inTagB),
            .inValA      (inValA),
            .inValB      (inValB),
            .resultValid (resultValid),
            .resultTag   (resultTag),
            .resultData  (resultData),
            .issueClear  (issueClear[i]),
            .busy        (busyVec[i]),
            .ready       (readyVec[i]),
            .op          (opVec[i]),
            .destTag     (tagVec[i]),
            .valA        (valAVec[i]),
            .valB        (valBVec[i])
        );
    end

    rsIssue issueInst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .readyVec     (readyVec),
        .opVec        (opVec),
        .tagVec       (tagVec),
        .valAVec      (valAVec),
        .valBVec      (valBVec),
        .issueClear   (issueClear),
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .issueTag     (issueTag),
        .issueA       (issueA),
        .issueB       (issueB),
        .creditReturn (creditReturn)
    );

    rsAlu aluInst (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issueValid  (issueValid),
        .issueOp     (issueOp),
        .issueTag    (issueTag),
        .issueA      (issueA),
        .issueB      (issueB),
        .resultValid (resultValid),
        .resultTag   (resultTag),
        .resultData  (resultData)
    );

endmodule

//--- verif/rsClock.sv
`timescale 1ns/1ps

module rsClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- verif/rsMonitor.sv
`timescale 1ns/1ps

module rsMonitor import rsPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 creditReturn,
    input  logic                 resultValid,
    input  logic [TagWidth-1:0]  resultTag,
    input  logic [DataWidth-1:0] resultData
);

    localparam int NumTags = 2 ** TagWidth;

    logic [DataWidth-1:0] expData [NumTags];
    int                   expKind [NumTags];  // 0 none, 1 expected, 2 must not appear.
    bit                   seen    [NumTags];
    int                   creditCount = 0;
    int                   creditBase  = 0;
    int                   errorCount  = 0;

    task automatic startTest();
        for (int t = 0; t < NumTags; t++) begin
            expKind[t] = 0;
            seen[t]    = 1'b0;
        end
        creditBase = creditCount;
    endtask

    task automatic rebaseCredits();
        creditBase = creditCount;
    endtask

    task automatic expectResult(input int tag, input logic [DataWidth-1:0] data);
        expKind[tag] = 1;
        expData[tag] = data;
    endtask

    task automatic forbidTag(input int tag);
        expKind[tag] = 2;
    endtask

    function automatic bit allSeen();
        for (int t = 0; t < NumTags; t++) begin
            if (expKind[t] == 1 && !seen[t]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic finishTest(input int accepted);
        for (int t = 0; t < NumTags; t++) begin
            if (expKind[t] == 1 && !seen[t]) begin
                $display("tag %0d never produced a result", t);
                errorCount++;
            end
        end
        if (creditCount - creditBase != accepted) begin
            $display("%0d credits came back for %0d accepted instructions",
                     creditCount - creditBase, accepted);
            errorCount++;
        end
    endtask

    // ****************************************
    // result bus and credit watch
    // ****************************************
    always @(posedge clk) begin
        if (!reset && !flush && creditReturn) begin
            creditCount++;
        end
        if (!reset && resultValid) begin
            if (expKind[resultTag] == 2) begin
                $display("tag %0d of a flushed group still produced a result", resultTag);
                errorCount++;
            end else if (expKind[resultTag] == 0) begin
                $display("unexpected result for tag %0d", resultTag);
                errorCount++;
            end else if (seen[resultTag]) begin
                $display("tag %0d produced a second result", resultTag);
                errorCount++;
            end else begin
                seen[resultTag] = 1'b1;
                if (resultData !== expData[resultTag]) begin
                    $display("** Error at %0t: resultData (tag %0d) expected %h actual %h",
                             $time, resultTag, expData[resultTag], resultData);
                    errorCount++;
                end
            end
        end
    end

endmodule

//--- verif/rsTop_chk.sv
`timescale 1ns/1ps

module rsTop_chk import rsPkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  flush,
    input logic                  inValid,
    input logic [NumEntries-1:0] busyVec,
    input logic [NumEntries-1:0] writeEnable,
    input logic [NumEntries-1:0] issueClear,
    input logic                  issueValid,
    input logic                  creditReturn,
    input logic                  resultValid
);

    int failCount = 0;

    writeFree: assert property (@(posedge clk) disable iff (reset)
        inValid |-> (|(writeEnable & ~busyVec)))
        else begin
            $error("dispatch found no free station slot");
            failCount++;
        end

    // a credit comes back exactly when a slot was released at the last edge.
    creditIssue: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(flush)) |->
            (creditReturn == (|($past(busyVec) & ~busyVec))))
        else begin
            $error("credit return does not match the slots released");
            failCount++;
        end

    issueResult: assert property (@(posedge clk) disable iff (reset)
        (issueValid && !flush) |=> resultValid)
        else begin
            $error("result did not follow issue by one cycle");
            failCount++;
        end

    // entries free at most one slot per edge outside flush.
    oneClear: assert property (@(posedge clk) disable iff (reset)
        (!$past(reset) && !$past(flush)) |->
            ($countones($past(busyVec) & ~busyVec) <= 1))
        else begin
            $error("more than one slot cleared in a cycle");
            failCount++;
        end

endmodule

bind rsTop rsTop_chk chkInst (
    .clk          (clk),
    .reset        (reset),
    .flush        (flush),
    .inValid      (inValid),
    .busyVec      (busyVec),
    .writeEnable  (writeEnable),
    .issueClear   (issueClear),
    .issueValid   (issueValid),
    .creditReturn (creditReturn),
    .resultValid  (resultValid)
);

//--- verif/rsTb.sv
`timescale 1ns/1ps

module rsTb import rsPkg::*; ();

    localparam int RecWords = 8;
    localparam int MaxRecs  = 64;

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 inValid;
    rsOp                  inOp;
    logic [TagWidth-1:0]  inDestTag;
    logic [TagWidth-1:0]  inTagA;
    logic [DataWidth-1:0] inValA;
    logic [TagWidth-1:0]  inTagB;
    logic [DataWidth-1:0] inValB;
    logic                 creditReturn;
    logic                 resultValid;
    logic [TagWidth-1:0]  resultTag;
    logic [DataWidth-1:0] resultData;

    logic [31:0] golden [RecWords*MaxRecs];
    int credits;
    int accepted     = 0;
    int acceptedBase = 0;
    int cycles       = 0;
    int cycleLimit   = 200;
    int numRecords   = 0;
    int testsRun     = 0;
    int testsFailed  = 0;
    int errorsBefore = 0;
    int currentTest  = 0;

    rsClock clockInst (.clk(clk), .reset(reset));

    rsTop rsTop_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .inValid      (inValid),
        .inOp         (inOp),
        .inDestTag    (inDestTag),
        .inTagA       (inTagA),
        .inValA       (inValA),
        .inTagB       (inTagB),
        .inValB       (inValB),
        .creditReturn (creditReturn),
        .resultValid  (resultValid),
        .resultTag    (resultTag),
        .resultData   (resultData)
    );

    rsMonitor monitorInst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .creditReturn (creditReturn),
        .resultValid  (resultValid),
        .resultTag    (resultTag),
        .resultData   (resultData)
    );

    // upstream credit counter.
    always @(posedge clk) begin
        if (reset || flush) begin
            credits <= CreditInit;
        end else begin
            credits <= credits - int'(inValid) + int'(creditReturn);
        end
        if (!reset && inValid) begin
            accepted <= accepted + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout after %0d cycles with results still outstanding", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // monitor mismatches plus assertion failures.
    function automatic int totalErrors();
        return monitorInst.errorCount + rsTop_inst.chkInst.failCount;
    endfunction

    task automatic sendRecord(input int base);
        while (credits == 0) begin
            @(negedge clk);  // stalled on credits.
        end
        if (golden[base] == 32'd2) begin
            monitorInst.expectResult(golden[base+2], golden[base+7]);
        end else begin
            monitorInst.forbidTag(golden[base+2]);
        end
        inOp      = rsOp'(golden[base+1][2:0]);
        inDestTag = golden[base+2][TagWidth-1:0];
        inTagA    = golden[base+3][TagWidth-1:0];
        inValA    = golden[base+4];
        inTagB    = golden[base+5][TagWidth-1:0];
        inValB    = golden[base+6];
        inValid   = 1'b1;
        @(negedge clk);
        inValid   = 1'b0;
    endtask

    task automatic drainResults();
        while (!monitorInst.allSeen()) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // room for stray results.
    endtask

    task automatic openTest(input int id);
        currentTest  = id;
        errorsBefore = totalErrors();
        acceptedBase = accepted;
        monitorInst.startTest();
    endtask

    task automatic closeTest();
        drainResults();
        monitorInst.finishTest(accepted - acceptedBase);
        testsRun++;
        if (totalErrors() != errorsBefore) begin
            testsFailed++;
            $display("test %0d failed", currentTest);
        end else begin
            $display("test %0d passed", currentTest);
        end
    endtask

    task automatic flushStation();
        drainResults();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        acceptedBase = accepted;  // no credits come back for flushed work.
        monitorInst.rebaseCredits();
    endtask

    // ****************************************
    // golden file walk
    // ****************************************
    initial begin
        int idx;
        int kind;
        bit testOpen;
        flush     = 1'b0;
        inValid   = 1'b0;
        inOp      = opAdd;
        inDestTag = '0;
        inTagA    = '0;
        inValA    = '0;
        inTagB    = '0;
        inValB    = '0;
        $readmemh("verif/rs_golden.txt", golden);
        for (int r = 0; r < MaxRecs; r++) begin
            if (golden[r*RecWords] === 32'd2 || golden[r*RecWords] === 32'd4) begin
                numRecords++;
            end
        end
        cycleLimit = 20 * numRecords + 200;
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        testOpen = 1'b0;
        idx      = 0;
        kind     = golden[0];
        while (kind >= 1 && kind <= 4) begin
            case (kind)
                1: begin
                    if (testOpen) begin
                        closeTest();
                    end
                    openTest(golden[idx*RecWords+1]);
                    testOpen = 1'b1;
                end
                3:       flushStation();
                default: sendRecord(idx * RecWords);
            endcase
            idx++;
            kind = (idx < MaxRecs) ? golden[idx*RecWords] : 0;
        end
        if (testOpen) begin
            closeTest();
        end
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed,
                 totalErrors());
        if (testsRun > 0 && testsFailed == 0 && totalErrors() == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- verif/rs_golden.txt
// kind op dest tagA valA tagB valB expect, all hex
// kind 1 test start (op = test id), 2 result expected, 3 flush, 4 must not appear, 0 end
1 1 0 0 00000000 0 00000000 00000000
2 0 1 0 00000005 0 00000003 00000008
2 1 2 0 00000003 0 00000005 fffffffe
2 2 3 0 f0f0f0f0 0 0ff00ff0 00f000f0
2 3 4 0 f0f00000 0 00000f0f f0f00f0f
2 4 5 0 aaaa5555 0 ffff0000 55555555
2 5 6 0 00000003 0 00000024 00000030
2 6 7 0 80000000 0 0000003f 00000001
2 7 8 0 ffffffff 0 00000001 00000001
1 2 0 0 00000000 0 00000000 00000000
2 0 1 0 0000000a 0 00000014 0000001e
2 0 2 1 00000000 0 00000002 00000020
2 5 3 2 00000000 0 00000001 00000040
2 1 4 3 00000000 1 00000000 00000022
2 4 5 4 00000000 2 00000000 00000002
2 7 6 5 00000000 0 00000003 00000001
1 3 0 0 00000000 0 00000000 00000000
2 0 1 8 00000000 0 00000001 00000101
2 1 2 8 00000000 0 00000010 000000f0
2 2 3 8 00000000 0 000001ff 00000100
2 3 4 8 00000000 0 0000000f 0000010f
2 4 5 8 00000000 0 00000101 00000001
2 5 6 8 00000000 0 00000004 00001000
2 6 7 8 00000000 0 00000008 00000001
2 0 8 0 00000080 0 00000080 00000100
2 0 9 e 00000000 0 00000001 00000041
2 0 a 0 00000002 e 00000000 00000042
2 7 b e 00000000 0 00000041 00000001
2 4 c e 00000000 e 00000000 00000000
2 3 d e 00000000 0 00000003 00000043
2 1 e 0 00000050 0 00000010 00000040
1 4 0 0 00000000 0 00000000 00000000
2 0 1 0 00000007 0 00000008 0000000f
4 0 2 f 00000000 0 00000001 00000000
4 3 3 0 00000001 f 00000000 00000000
3 0 0 0 00000000 0 00000000 00000000
2 0 4 0 00000004 0 00000100 00000104
2 0 5 0 00000005 0 00000100 00000105
2 0 6 0 00000006 0 00000100 00000106
2 0 7 0 00000007 0 00000100 00000107
2 0 8 0 00000008 0 00000100 00000108
2 0 9 0 00000009 0 00000100 00000109
2 0 a 0 0000000a 0 00000100 0000010a
2 0 b 0 0000000b 0 00000100 0000010b
1 5 0 0 00000000 0 00000000 00000000
2 0 1 0 00000001 0 00000002 00000003
2 1 2 1 00000000 0 00000001 00000002
2 4 3 0 000000f0 0 0000000f 000000ff
2 0 4 2 00000000 3 00000000 00000101
2 2 5 0 0000ff00 0 00000ff0 00000f00
2 6 6 4 00000000 0 00000001 00000080
2 7 7 0 fffffffe 5 00000000 00000001
0 0 0 0 00000000 0 00000000 00000000

//--- sources.f
source/rsPkg.sv
source/rsEntry.sv
source/rsDispatch.sv
source/rsIssue.sv
source/rsAlu.sv
source/rsTop.sv
verif/rsClock.sv
verif/rsMonitor.sv
verif/rsTop_chk.sv
verif/rsTb.sv
